// ==== verilog.f ====
design/replica_pkg.sv
design/anneal_pkg.sv
design/node_control.sv
design/distance_unit.sv
design/accept_unit.sv
design/wb_node_regs.sv
design/replica_node.sv
tests/replica_node_asserts.sv
tests/replica_node_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

rm -f run.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module replica_node_tb \
    --Mdir obj_dir \
    -o replica_node_sim \
    -f verilog.f

./obj_dir/replica_node_sim | tee run.log

if grep -q "TEST RESULT: PASS" run.log; then
    exit 0
else
    echo "Simulation did not pass, see run.log"
    exit 1
fi

// ==== tests/replica_node_tb.sv ====
`timescale 1ns/1ns

module replica_node_tb
    import replica_pkg::*, anneal_pkg::*;
;

    localparam int node_id     = 2;
    localparam int run_count   = 8;
    localparam int max_rounds  = 8 * 3 + 5;
    localparam int watchdog_ns = run_count * max_rounds * 32 * 4 * 2;

    logic        clk;
    logic        reset;
    wb_req_t     wb_req;
    wb_rsp_t     wb_rsp;
    base_id_t    or_rn_base_id;
    base_id_t    tw_rn_base_id;
    base_id_t    or_dd_base_id;
    base_id_t    tw_dd_base_id;
    base_id_t    or_ex_base_id;
    base_id_t    tw_ex_base_id;
    int          value_errors;
    int          other_errors;
    logic [31:0] lcg_state;
    longint      cycle = 0;

    replica_node #(
        .node_id (node_id)
    ) dut (
        .clk           (clk),
        .reset         (reset),
        .wb_req        (wb_req),
        .wb_rsp        (wb_rsp),
        .or_rn_base_id (or_rn_base_id),
        .tw_rn_base_id (tw_rn_base_id),
        .or_dd_base_id (or_dd_base_id),
        .tw_dd_base_id (tw_dd_base_id),
        .or_ex_base_id (or_ex_base_id),
        .tw_ex_base_id (tw_ex_base_id)
    );

    bind node_control replica_node_asserts u_node_asserts (
        .clk       (clk),
        .reset     (reset),
        .running   (running),
        .tw_opt_en (tw_opt_en),
        .exp_init  (exp_init),
        .exp_fin   (exp_fin)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) cycle <= cycle + 1;

    // ------------------------------------------------------------
    // Random numbers and reference model
    // ------------------------------------------------------------
    function automatic logic [31:0] next_random();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    function automatic int pick(input int lo, input int hi);
        logic [31:0] r;
        r = next_random();
        return lo + int'((r >> 16) % (hi - lo + 1));
    endfunction

    // Taylor series of exp(-delta), n = 15 down to 1
    function automatic q15_t horner_exp(input q15_t delta);
        longint x;
        longint acc;
        longint prod;
        x   = -longint'(delta);
        acc = 32768;
        for (int n = 15; n >= 1; n--) begin
            prod = (x * acc) >>> 15;
            acc  = 32768 + ((prod * (32768 / n)) >>> 15);
            acc  = longint'(q15_t'(acc));  // 32-bit register
        end
        return q15_t'(acc);
    endfunction

    // Base id at the start of round r, lane enabled from round first for en rounds
    function automatic base_id_t lane_base(input int r, input int first, input int en);
        int steps;
        steps = r - first;
        if (steps < 0)
            steps = 0;
        if (steps > en)
            steps = en;
        return base_id_t'((node_id + steps) % base_num);
    endfunction

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        assert (actual == expected)
        else begin
            value_errors++;
            $display("ERROR %s expected 0x%08h actual 0x%08h", name, expected, actual);
        end
    endtask

    // ------------------------------------------------------------
    // Wishbone master, called on a falling edge
    // ------------------------------------------------------------
    task automatic bus_cycle(input logic we, input logic [7:0] adr,
                             input logic [31:0] wdata, output logic [31:0] rdata);
        int waited;
        waited = 0;
        wb_req = '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, dat_w: wdata};
        @(negedge clk);
        while (!wb_rsp.ack && waited < 16) begin
            waited++;
            @(negedge clk);
        end
        assert (wb_rsp.ack)
        else begin
            other_errors++;
            $display("No Wishbone ack for address 0x%02h", adr);
        end
        rdata  = wb_rsp.dat_r;
        wb_req = '0;
        @(negedge clk);
    endtask

    task automatic write_reg(input logic [7:0] adr, input logic [31:0] data);
        logic [31:0] unused;
        bus_cycle(1'b1, adr, data, unused);
    endtask

    task automatic read_reg(input logic [7:0] adr, output logic [31:0] data);
        bus_cycle(1'b0, adr, 32'd0, data);
    endtask

    task automatic run_test(input int run);
        q15_t        ops [2][operand_num];
        q15_t        delta [2];
        q15_t        exp_expect;
        q15_t        thresh;
        int          times;
        int          rounds;
        int          accepted;
        int          limit;
        int          first [2];
        longint      start_cycle;
        logic [31:0] rdata;
        string       lane [2] = '{"or", "tw"};
        for (int l = 0; l < 2; l++) begin
            for (int k = 0; k < operand_num; k++) begin
                ops[l][k] = pick(0, 4095);
                write_reg(8'(REG_OR_OP + l * operand_num + k), ops[l][k]);
            end
        end
        times  = pick(1, 3);
        thresh = pick(24576, 40959);
        rounds = 8 * times + 5;
        limit  = rounds * 32 + 8;  // Plus bus latency
        delta[0] = ops[0][KP] - ops[0][KM] + ops[0][LN] - ops[0][LP];
        delta[1] = ops[1][LM] - ops[1][KM] + ops[1][KN] - ops[1][LN];
        first    = '{1, 5};    // tw lags the or lane by 4 rounds

        write_reg(REG_THRESH, thresh);
        write_reg(REG_CTRL, times);
        start_cycle = cycle;
        read_reg(REG_STATUS, rdata);
        check_value($sformatf("run %0d status while running", run), 1, rdata);
        write_reg(REG_CTRL, times + 1);
        read_reg(REG_CTRL, rdata);
        check_value($sformatf("run %0d run_times after busy write", run), times, rdata);

        while (rdata[0] !== 1'b0 || rdata == times) begin
            if (cycle - start_cycle > limit)
                break;
            read_reg(REG_STATUS, rdata);
        end
        assert (cycle - start_cycle <= limit)
        else begin
            other_errors++;
            $display("Run %0d still running after %0d cycles", run, limit);
        end

        for (int l = 0; l < 2; l++) begin
            exp_expect = horner_exp(delta[l]);
            accepted   = (delta[l] <= 0 || exp_expect >= thresh) ? 8 * times : 0;
            read_reg(8'(REG_OR_ACC + l), rdata);
            check_value($sformatf("run %0d %s accept count", run, lane[l]), accepted, rdata);
            read_reg(8'(REG_OR_ENERGY + l), rdata);
            check_value($sformatf("run %0d %s energy", run, lane[l]),
                        q15_t'(accepted * delta[l]), rdata);
            read_reg(8'(REG_OR_EXP + l), rdata);
            check_value($sformatf("run %0d %s exp", run, lane[l]), exp_expect, rdata);
        end

        check_value($sformatf("run %0d or rn id", run), lane_base(rounds + 1, first[0], 8 * times),
                    or_rn_base_id);
        check_value($sformatf("run %0d or dd id", run), lane_base(rounds, first[0], 8 * times),
                    or_dd_base_id);
        check_value($sformatf("run %0d or ex id", run), lane_base(rounds - 3, first[0], 8 * times),
                    or_ex_base_id);
        check_value($sformatf("run %0d tw rn id", run), lane_base(rounds + 1, first[1], 8 * times),
                    tw_rn_base_id);
        check_value($sformatf("run %0d tw dd id", run), lane_base(rounds, first[1], 8 * times),
                    tw_dd_base_id);
        check_value($sformatf("run %0d tw ex id", run), lane_base(rounds - 3, first[1], 8 * times),
                    tw_ex_base_id);
    endtask

    // ------------------------------------------------------------
    // Main sequence
    // ------------------------------------------------------------
    initial begin
        logic [31:0] rdata;
        logic [7:0]  zero_addrs [$] = '{REG_CTRL, REG_STATUS, REG_THRESH, REG_OR_ENERGY,
                                        REG_TW_ENERGY, REG_OR_ACC, REG_TW_ACC, REG_OR_EXP,
                                        REG_TW_EXP, 8'h0F, 8'h16, 8'hFF};
        value_errors = 0;
        other_errors = 0;
        lcg_state    = 32'd60065;
        wb_req       = '0;
        reset        = 1'b1;
        repeat (3) @(negedge clk);
        reset = 1'b0;

        foreach (zero_addrs[i]) begin
            read_reg(zero_addrs[i], rdata);
            check_value($sformatf("reset read 0x%02h", zero_addrs[i]), 0, rdata);
        end

        for (int run = 0; run < run_count; run++)
            run_test(run);

        $display("Checks done: %0d value errors, %0d other errors", value_errors, other_errors);
        if (value_errors + other_errors == 0)
            $display("TEST RESULT: PASS");
        else
            $display("TEST RESULT: FAIL");
        $finish;
    end

    initial begin
        #(watchdog_ns);
        $display("Watchdog expired, the runs did not finish in time");
        $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule

// ==== tests/replica_node_asserts.sv ====
`timescale 1ns/1ns

module replica_node_asserts (
    input logic clk,
    input logic reset,
    input logic running,
    input logic tw_opt_en,
    input logic exp_init,
    input logic exp_fin
);

    // ------------------------------------------------------------
    // Exp schedule strobes
    // ------------------------------------------------------------
    init_one_cycle: assert property (@(posedge clk) disable iff (reset)
        exp_init |=> !exp_init)
        else $error("exp_init stayed high for more than one cycle");

    fin_one_cycle: assert property (@(posedge clk) disable iff (reset)
        exp_fin |=> !exp_fin)
        else $error("exp_fin stayed high for more than one cycle");

    fin_after_init: assert property (@(posedge clk) disable iff (reset)
        exp_fin |-> $past(exp_init, 17))
        else $error("exp_fin without exp_init 17 cycles before");

    init_then_fin: assert property (@(posedge clk) disable iff (reset)
        $past(exp_init, 17) |-> exp_fin)
        else $error("exp_init not followed by exp_fin after 17 cycles");

    // tw lane only works inside a run
    tw_inside_run: assert property (@(posedge clk) disable iff (reset)
        !running |-> !tw_opt_en)
        else $error("tw_opt_en high while not running");

endmodule

// ==== design/replica_node.sv ====
`timescale 1ns/1ns

module replica_node
    import replica_pkg::*, anneal_pkg::*;
#(
    parameter int node_id = 0
) (
    input  logic     clk,
    input  logic     reset,
    input  wb_req_t  wb_req,
    output wb_rsp_t  wb_rsp,
    output base_id_t or_rn_base_id,
    output base_id_t tw_rn_base_id,
    output base_id_t or_dd_base_id,
    output base_id_t tw_dd_base_id,
    output base_id_t or_ex_base_id,
    output base_id_t tw_ex_base_id
);

    logic                   run_write;
    logic                   clear;
    logic                   running;
    sweep_cnt_t             run_times;
    q15_t                   threshold;
    q15_t [operand_num-1:0] or_operands;
    q15_t [operand_num-1:0] tw_operands;
    logic                   or_opt_en;
    logic                   tw_opt_en;
    distance_command_t      or_distance_com;
    distance_command_t      tw_distance_com;
    logic                   exp_init;
    logic                   exp_run;
    logic                   exp_fin;
    recip_t                 exp_recip;
    q15_t                   or_delta;
    q15_t                   tw_delta;
    logic                   or_delta_valid;
    logic                   tw_delta_valid;
    energy_t                or_energy;
    energy_t                tw_energy;
    sweep_cnt_t             or_acc;
    sweep_cnt_t             tw_acc;
    q15_t                   or_exp;
    q15_t                   tw_exp;

    node_control #(
        .node_id (node_id)
    ) u_node_control (
        .clk             (clk),
        .reset           (reset),
        .run_write       (run_write),
        .run_times       (run_times),
        .running         (running),
        .or_rn_base_id   (or_rn_base_id),
        .tw_rn_base_id   (tw_rn_base_id),
        .or_dd_base_id   (or_dd_base_id),
        .tw_dd_base_id   (tw_dd_base_id),
        .or_ex_base_id   (or_ex_base_id),
        .tw_ex_base_id   (tw_ex_base_id),
        .or_opt_en       (or_opt_en),
        .tw_opt_en       (tw_opt_en),
        .or_distance_com (or_distance_com),
        .tw_distance_com (tw_distance_com),
        .exp_init        (exp_init),
        .exp_run         (exp_run),
        .exp_fin         (exp_fin),
        .exp_recip       (exp_recip)
    );

    // ------------------------------------------------------------
    // Lane datapaths, capture on cycle 9 together with exp_init
    // ------------------------------------------------------------
    distance_unit u_or_dist (
        .clk         (clk),
        .reset       (reset),
        .command     (or_distance_com),
        .lane_en     (or_opt_en),
        .capture     (exp_init),
        .operands    (or_operands),
        .delta       (or_delta),
        .delta_valid (or_delta_valid)
    );

    distance_unit u_tw_dist (
        .clk         (clk),
        .reset       (reset),
        .command     (tw_distance_com),
        .lane_en     (tw_opt_en),
        .capture     (exp_init),
        .operands    (tw_operands),
        .delta       (tw_delta),
        .delta_valid (tw_delta_valid)
    );

    accept_unit u_or_acc (
        .clk         (clk),
        .reset       (reset),
        .exp_init    (exp_init),
        .exp_run     (exp_run),
        .exp_fin     (exp_fin),
        .exp_recip   (exp_recip),
        .delta       (or_delta),
        .delta_valid (or_delta_valid),
        .threshold   (threshold),
        .clear       (clear),
        .exp_value   (or_exp),
        .energy      (or_energy),
        .accept_cnt  (or_acc)
    );

    accept_unit u_tw_acc (
        .clk         (clk),
        .reset       (reset),
        .exp_init    (exp_init),
        .exp_run     (exp_run),
        .exp_fin     (exp_fin),
        .exp_recip   (exp_recip),
        .delta       (tw_delta),
        .delta_valid (tw_delta_valid),
        .threshold   (threshold),
        .clear       (clear),
        .exp_value   (tw_exp),
        .energy      (tw_energy),
        .accept_cnt  (tw_acc)
    );

    wb_node_regs u_wb_node_regs (
        .clk         (clk),
        .reset       (reset),
        .wb_req      (wb_req),
        .running     (running),
        .or_energy   (or_energy),
        .tw_energy   (tw_energy),
        .or_acc      (or_acc),
        .tw_acc      (tw_acc),
        .or_exp      (or_exp),
        .tw_exp      (tw_exp),
        .wb_rsp      (wb_rsp),
        .run_write   (run_write),
        .run_times   (run_times),
        .threshold   (threshold),
        .or_operands (or_operands),
        .tw_operands (tw_operands),
        .clear       (clear)
    );

endmodule

// ==== design/wb_node_regs.sv ====
`timescale 1ns/1ns

module wb_node_regs
    import replica_pkg::*, anneal_pkg::*;
(
    input  logic                    clk,
    input  logic                    reset,
    input  wb_req_t                 wb_req,
    input  logic                    running,
    input  energy_t                 or_energy,
    input  energy_t                 tw_energy,
    input  sweep_cnt_t              or_acc,
    input  sweep_cnt_t              tw_acc,
    input  q15_t                    or_exp,
    input  q15_t                    tw_exp,
    output wb_rsp_t                 wb_rsp,
    output logic                    run_write,
    output sweep_cnt_t              run_times,
    output q15_t                    threshold,
    output q15_t [operand_num-1:0]  or_operands,
    output q15_t [operand_num-1:0]  tw_operands,
    output logic                    clear
);

    logic        req;
    logic        wr;
    logic        start;
    logic        ack_q;
    logic [31:0] dat_q;
    logic [31:0] rd_data;

    assign req   = wb_req.cyc && wb_req.stb && !ack_q;  // One ack per request
    assign wr    = req && wb_req.we;
    assign start = wr && (wb_req.adr == REG_CTRL) && !running;

    // ------------------------------------------------------------
    // Readback, operand registers are write-only
    // ------------------------------------------------------------
    always_comb begin
        case (wb_req.adr)
            REG_CTRL:      rd_data = 32'(run_times);
            REG_STATUS:    rd_data = {31'd0, running};
            REG_THRESH:    rd_data = threshold;
            REG_OR_ENERGY: rd_data = or_energy;
            REG_TW_ENERGY: rd_data = tw_energy;
            REG_OR_ACC:    rd_data = 32'(or_acc);
            REG_TW_ACC:    rd_data = 32'(tw_acc);
            REG_OR_EXP:    rd_data = or_exp;
            REG_TW_EXP:    rd_data = tw_exp;
            default:       rd_data = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset)
            ack_q <= 1'b0;
        else
            ack_q <= req;
    end

    always_ff @(posedge clk) begin
        if (req)
            dat_q <= rd_data;
    end

    assign wb_rsp = '{ack: ack_q, dat_r: dat_q};

    // ------------------------------------------------------------
    // Writes
    // ------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            run_write <= 1'b0;
            run_times <= '0;
            threshold <= '0;
        end else begin
            run_write <= start;  // Start is ignored while running
            if (start)
                run_times <= sweep_cnt_t'(wb_req.dat_w);
            if (wr && wb_req.adr == REG_THRESH)
                threshold <= wb_req.dat_w;
        end
    end

    always_ff @(posedge clk) begin
        if (wr && wb_req.adr >= REG_OR_OP && wb_req.adr < REG_OR_OP + operand_num)
            or_operands[3'(wb_req.adr - REG_OR_OP)] <= wb_req.dat_w;
        if (wr && wb_req.adr >= REG_TW_OP && wb_req.adr < REG_TW_OP + operand_num)
            tw_operands[3'(wb_req.adr - REG_TW_OP)] <= wb_req.dat_w;
    end

    assign clear = run_write;  // Results restart with every run

endmodule

// ==== design/accept_unit.sv ====
`timescale 1ns/1ns

module accept_unit
    import replica_pkg::*, anneal_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  logic       exp_init,
    input  logic       exp_run,
    input  logic       exp_fin,
    input  recip_t     exp_recip,
    input  q15_t       delta,
    input  logic       delta_valid,
    input  q15_t       threshold,
    input  logic       clear,
    output q15_t       exp_value,
    output energy_t    energy,
    output sweep_cnt_t accept_cnt
);

    q15_t               x;
    q15_t               acc;
    logic signed [63:0] x_acc;
    logic signed [63:0] step;
    logic               accept;

    // Delta is held from its capture until the next round's capture
    assign x     = -delta;
    assign x_acc = x * acc;
    assign step  = (x_acc >>> 15) * $signed({47'd0, exp_recip});

    // Horner form, acc = 1 + x/n * acc
    always_ff @(posedge clk) begin
        if (exp_init)
            acc <= q15_one;
        else if (exp_run)
            acc <= q15_t'(q15_one + (step >>> 15));
    end

    assign accept = delta_valid && ((delta <= 0) || (acc >= threshold));

    always_ff @(posedge clk) begin
        if (reset) begin
            exp_value  <= '0;
            energy     <= '0;
            accept_cnt <= '0;
        end else begin
            if (exp_fin)
                exp_value <= acc;
            if (clear) begin
                energy     <= '0;
                accept_cnt <= '0;
            end else if (exp_fin && accept) begin
                energy     <= energy + delta;
                accept_cnt <= accept_cnt + 1'b1;
            end
        end
    end

endmodule

// ==== design/distance_unit.sv ====
`timescale 1ns/1ns

module distance_unit
    import replica_pkg::*, anneal_pkg::*;
(
    input  logic                    clk,
    input  logic                    reset,
    input  distance_command_t       command,
    input  logic                    lane_en,
    input  logic                    capture,
    input  q15_t [operand_num-1:0]  operands,
    output q15_t                    delta,
    output logic                    delta_valid
);

    q15_t sum;
    q15_t operand;

    assign operand = operands[command.sel];

    always_ff @(posedge clk) begin
        case (command.op)
            ZERO: sum <= '0;
            PLS:  sum <= sum + operand;
            MNS:  sum <= sum - operand;
            DNOP: sum <= sum;
        endcase
    end

    always_ff @(posedge clk) begin
        if (capture)
            delta <= sum;
    end

    // Tag the delta with the lane enable of its round
    always_ff @(posedge clk) begin
        if (reset)
            delta_valid <= 1'b0;
        else if (capture)
            delta_valid <= lane_en;
    end

endmodule

// ==== design/node_control.sv ====
`timescale 1ns/1ns

module node_control
    import replica_pkg::*, anneal_pkg::*;
#(
    parameter int node_id = 0
) (
    input  logic              clk,
    input  logic              reset,
    input  logic              run_write,
    input  sweep_cnt_t        run_times,
    output logic              running,

    output base_id_t          or_rn_base_id,
    output base_id_t          tw_rn_base_id,
    output base_id_t          or_dd_base_id,
    output base_id_t          tw_dd_base_id,
    output base_id_t          or_ex_base_id,
    output base_id_t          tw_ex_base_id,

    output logic              or_opt_en,
    output logic              tw_opt_en,

    output distance_command_t or_distance_com,
    output distance_command_t tw_distance_com,

    output logic              exp_init,
    output logic              exp_run,
    output logic              exp_fin,
    output recip_t            exp_recip
);

    // Node-unique starting slot, a sweep ends one slot before it
    localparam base_id_t start_base    = base_id_t'(node_id % base_num);
    localparam base_id_t last_base     = base_id_t'((node_id + base_num - 1) % base_num);
    localparam base_id_t tw_start_base = base_id_t'((node_id + tw_lag) % base_num);

    round_cnt_t      cycle_cnt;
    sweep_cnt_t      run_limit;
    sweep_cnt_t      or_sweep;
    sweep_cnt_t      tw_sweep;
    base_id_t [4:1]  or_dl;
    base_id_t [4:1]  tw_dl;
    logic            round_end;
    logic            or_done;
    logic            tw_done;

    function automatic distance_command_t cmd(input operand_sel_t s, input dist_op_t o);
        return '{sel: s, op: o};
    endfunction

    assign round_end = running && (cycle_cnt == round_cnt_t'(round_last));
    assign or_done   = or_opt_en && (or_rn_base_id == last_base) &&
                       (or_sweep == run_limit - 1'b1);
    assign tw_done   = tw_opt_en && (tw_rn_base_id == last_base) &&
                       (tw_sweep == run_limit - 1'b1);

    // ------------------------------------------------------------
    // Round counter and run state
    // ------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            running   <= 1'b0;
            cycle_cnt <= '0;
            run_limit <= '0;
        end else begin
            cycle_cnt <= running ? cycle_cnt + 1'b1 : '0;
            if (run_write) begin
                running   <= 1'b1;
                run_limit <= (run_times == '0) ? sweep_cnt_t'(1) : run_times;
            end else if (round_end && !or_opt_en && !tw_opt_en) begin
                running <= 1'b0;  // After one trailing round
            end
        end
    end

    // Lane enables and sweep counters
    always_ff @(posedge clk) begin
        if (reset) begin
            or_opt_en <= 1'b0;
            tw_opt_en <= 1'b0;
            or_sweep  <= '0;
            tw_sweep  <= '0;
        end else begin
            if (run_write)
                or_opt_en <= 1'b1;
            else if (round_end && or_done)
                or_opt_en <= 1'b0;

            if (round_end && or_opt_en && or_sweep == '0 && or_rn_base_id == tw_start_base)
                tw_opt_en <= 1'b1;
            else if (round_end && tw_done)
                tw_opt_en <= 1'b0;

            if (run_write) begin
                or_sweep <= '0;
                tw_sweep <= '0;
            end else if (round_end) begin
                if (or_opt_en && or_rn_base_id == last_base)
                    or_sweep <= or_sweep + 1'b1;
                if (tw_opt_en && tw_rn_base_id == last_base)
                    tw_sweep <= tw_sweep + 1'b1;
            end
        end
    end

    // ------------------------------------------------------------
    // Base ids, rn stepping and dd/ex delay lines
    // ------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            or_rn_base_id <= start_base;
            tw_rn_base_id <= start_base;
            or_dl         <= {4{start_base}};
            tw_dl         <= {4{start_base}};
        end else if (round_end) begin
            if (or_opt_en)
                or_rn_base_id <= or_rn_base_id + 1'b1;  // Wraps at base_num
            if (tw_opt_en)
                tw_rn_base_id <= tw_rn_base_id + 1'b1;
            or_dl <= {or_dl[3:1], or_rn_base_id};
            tw_dl <= {tw_dl[3:1], tw_rn_base_id};
        end
    end

    assign or_dd_base_id = or_dl[1];
    assign tw_dd_base_id = tw_dl[1];
    assign or_ex_base_id = or_dl[4];
    assign tw_ex_base_id = tw_dl[4];

    // Commands leave the register on cycles 2 to 8
    always_ff @(posedge clk) begin
        if (reset) begin
            or_distance_com <= cmd(KN, DNOP);
            tw_distance_com <= cmd(KN, DNOP);
        end else begin
            case (cycle_cnt)
                5'd1:    or_distance_com <= cmd(KN, ZERO);
                5'd2:    or_distance_com <= cmd(KM, MNS);
                5'd3:    or_distance_com <= cmd(KP, PLS);
                5'd4:    or_distance_com <= cmd(KN, MNS);
                5'd5:    or_distance_com <= cmd(LN, PLS);
                5'd6:    or_distance_com <= cmd(LP, MNS);
                5'd7:    or_distance_com <= cmd(KN, PLS);
                default: or_distance_com <= cmd(KN, DNOP);
            endcase
            case (cycle_cnt)
                5'd1:    tw_distance_com <= cmd(KN, ZERO);
                5'd2:    tw_distance_com <= cmd(KM, MNS);
                5'd3:    tw_distance_com <= cmd(LM, PLS);
                5'd4:    tw_distance_com <= cmd(LN, MNS);
                5'd5:    tw_distance_com <= cmd(KN, PLS);
                default: tw_distance_com <= cmd(KN, DNOP);
            endcase
        end
    end

    // ------------------------------------------------------------
    // Exp schedule, terms n = 15 down to 1 on cycles 10 to 24
    // ------------------------------------------------------------
    assign exp_init = (cycle_cnt == round_cnt_t'(capture_cycle));
    assign exp_run  = (cycle_cnt > round_cnt_t'(capture_cycle)) &&
                      (cycle_cnt <= round_cnt_t'(capture_cycle + exp_steps));
    assign exp_fin  = (cycle_cnt == round_cnt_t'(exp_fin_cycle));

    always_ff @(posedge clk) begin
        for (int k = 1; k <= exp_steps; k++) begin
            if (cycle_cnt == round_cnt_t'(capture_cycle + exp_steps - k))
                exp_recip <= recip_t'(q15_one / k);
        end
    end

endmodule

// ==== design/anneal_pkg.sv ====
package anneal_pkg;

    typedef logic signed [31:0] q15_t;
    typedef logic [16:0]        recip_t;
    typedef logic signed [31:0] energy_t;

    localparam q15_t q15_one = 32'sd32768;

    // ------------------------------------------------------------
    // Wishbone classic
    // ------------------------------------------------------------
    typedef struct packed {
        logic        cyc;
        logic        stb;
        logic        we;
        logic [7:0]  adr;
        logic [31:0] dat_w;
    } wb_req_t;

    typedef struct packed {
        logic        ack;
        logic [31:0] dat_r;
    } wb_rsp_t;

    // Register map
    localparam logic [7:0] REG_CTRL      = 8'h00;
    localparam logic [7:0] REG_STATUS    = 8'h01;
    localparam logic [7:0] REG_THRESH    = 8'h02;
    localparam logic [7:0] REG_OR_OP     = 8'h03;  // KN .. LM at 0x03 to 0x08
    localparam logic [7:0] REG_TW_OP     = 8'h09;  // KN .. LM at 0x09 to 0x0E
    localparam logic [7:0] REG_OR_ENERGY = 8'h10;
    localparam logic [7:0] REG_TW_ENERGY = 8'h11;
    localparam logic [7:0] REG_OR_ACC    = 8'h12;
    localparam logic [7:0] REG_TW_ACC    = 8'h13;
    localparam logic [7:0] REG_OR_EXP    = 8'h14;
    localparam logic [7:0] REG_TW_EXP    = 8'h15;

endpackage

// ==== design/replica_pkg.sv ====
package replica_pkg;

    // Base slots of one node
    localparam int base_num = 8;
    localparam int base_log = 3;

    typedef logic [base_log-1:0] base_id_t;

    // ------------------------------------------------------------
    // Distance command stream
    // ------------------------------------------------------------
    typedef enum logic [2:0] {
        KN,
        KM,
        KP,
        LN,
        LP,
        LM
    } operand_sel_t;

    typedef enum logic [1:0] {
        ZERO,   // Clear accumulator
        PLS,
        MNS,
        DNOP    // Hold
    } dist_op_t;

    typedef struct packed {
        operand_sel_t sel;
        dist_op_t     op;
    } distance_command_t;

    localparam int operand_num = 6;

    // ------------------------------------------------------------
    // Round schedule
    // ------------------------------------------------------------
    typedef logic [4:0]  round_cnt_t;
    typedef logic [23:0] sweep_cnt_t;

    localparam int round_last    = 31;
    localparam int capture_cycle = 9;    // Delta capture and exp_init
    localparam int exp_steps     = 15;   // Taylor terms, one per cycle
    localparam int exp_fin_cycle = 26;
    localparam int tw_lag        = 3;    // tw lane starts after this or base

endpackage
